// File: design/console_pkg.sv
`default_nettype none

package console_pkg;

    // ======================================================================
    // heartbeat
    // ======================================================================

    // top bit drives the LED
    localparam int heartbeat_bits = 24;

    // ======================================================================
    // console write word
    // ======================================================================

    // one character per cycle with write high
    // no back-pressure from the console side
    typedef struct packed {
        logic        write;
        logic [31:0] data;
    } console_word_t;

    // a captured byte seen whole or split into hex digits
    typedef union packed {
        logic [7:0] whole;
        struct packed {
            logic [3:0] hi;
            logic [3:0] lo;
        } nib;
    } byte_view_u;

    // ascii codes
    localparam logic [7:0] char_k    = 8'h4B;
    localparam logic [7:0] char_zero = 8'h30;
    localparam logic [7:0] char_a    = 8'h41;

    // dump phases per byte
    localparam logic [1:0] ph_gap = 2'd0;
    localparam logic [1:0] ph_hi  = 2'd1;
    localparam logic [1:0] ph_lo  = 2'd2;

endpackage

`default_nettype wire

// File: design/hex_console.sv
`timescale 1ns/100ps
`default_nettype none

module hex_console (
    input  logic                       CLOCK_50,
    input  logic                       KEY0,
    input  logic                       card_up,
    input  sd_pkg::capture_buf_t       buffer,
    input  logic                       full,
    output console_pkg::console_word_t console
);

    // gap then high digit then low digit
    logic [1:0]              phase;
    // byte being printed
    // reaching capture_bytes ends the dump
    sd_pkg::byte_idx_t       print_idx;
    console_pkg::byte_view_u cur_byte;
    logic                    dump_on;
    logic                    next_write;
    logic [7:0]              next_char;
    logic                    write_q;
    logic [31:0]             data_q;

    // nibble to upper-case hex digit
    function automatic logic [7:0] hex_char(input logic [3:0] nib);
        logic [7:0] wide;
        wide = {4'h0, nib};
        if (nib < 4'd10) begin
            return console_pkg::char_zero + wide;
        end
        return console_pkg::char_a + wide - 8'd10;
    endfunction

    // ======================================================================
    // character select
    // ======================================================================

    // current byte through the nibble view
    always_comb begin
        cur_byte.whole = buffer[print_idx[3:0]];
    end

    assign dump_on = full && (print_idx != sd_pkg::byte_idx_t'(sd_pkg::capture_bytes));

    always_comb begin
        next_write = 1'b0;
        next_char  = console_pkg::char_k;
        // greeting first
        if (card_up) begin
            next_write = 1'b1;
            next_char  = console_pkg::char_k;
        end else if (dump_on && phase == console_pkg::ph_hi) begin
            next_write = 1'b1;
            next_char  = hex_char(cur_byte.nib.hi);
        end else if (dump_on && phase == console_pkg::ph_lo) begin
            next_write = 1'b1;
            next_char  = hex_char(cur_byte.nib.lo);
        end
    end

    // ======================================================================
    // dump sequencer
    // ======================================================================

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            write_q   <= 1'b0;
            phase     <= console_pkg::ph_gap;
            print_idx <= '0;
        end else begin
            write_q <= next_write;
            // dump waits out a greeting cycle
            if (!card_up && dump_on) begin
                case (phase)
                    console_pkg::ph_gap: begin
                        phase <= console_pkg::ph_hi;
                    end
                    console_pkg::ph_hi: begin
                        phase <= console_pkg::ph_lo;
                    end
                    default: begin
                        // low digit done so step to next byte
                        phase     <= console_pkg::ph_gap;
                        print_idx <= print_idx + sd_pkg::byte_idx_t'(1);
                    end
                endcase
            end
        end
    end

    // character word only loaded with a write
    always_ff @(posedge CLOCK_50) begin
        if (next_write) begin
            data_q <= {24'h0, next_char};
        end
    end

    assign console = '{write: write_q, data: data_q};

    // console is byte-wide in a 32-bit word
    console_upper_zero: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        console.write |-> (console.data[31:8] == '0)
    ) else $error("console write with nonzero upper data bits");

endmodule

`default_nettype wire

// File: design/sd_dump_top.sv
`timescale 1ns/100ps
`default_nettype none

module sd_dump_top (
    input  logic                       CLOCK_50,
    input  logic                       KEY0,
    input  logic                       sd_ready,
    input  sd_pkg::sd_byte_t           sd_in,
    output logic                       ledr0,
    output logic                       sd_pulse,
    output logic                       sd_rd,
    output console_pkg::console_word_t console
);

    // ======================================================================
    // internal links
    // ======================================================================

    // greeting strobe into the printer
    logic                 card_up;
    // captured head and its ready level
    sd_pkg::capture_buf_t buffer;
    logic                 full;

    // ======================================================================
    // heartbeat and SD pacing
    // ======================================================================

    tick_gen tick_gen_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .ledr0    (ledr0),
        .sd_pulse (sd_pulse)
    );

    // ======================================================================
    // card side
    // ======================================================================

    sector_capture sector_capture_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .sd_ready (sd_ready),
        .sd_in    (sd_in),
        .sd_rd    (sd_rd),
        .card_up  (card_up),
        .buffer   (buffer),
        .full     (full)
    );

    // ======================================================================
    // console side
    // ======================================================================

    hex_console hex_console_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .card_up  (card_up),
        .buffer   (buffer),
        .full     (full),
        .console  (console)
    );

endmodule

`default_nettype wire

// File: design/sd_pkg.sv
`default_nettype none

package sd_pkg;

    // ======================================================================
    // capture sizing
    // ======================================================================

    // bytes kept from the head of the sector
    localparam int capture_bytes = 16;

    // one spare bit so the count can sit at capture_bytes
    typedef logic [4:0] byte_idx_t;

    // slow strobe divider width
    // 512 system clocks per strobe
    localparam int pulse_div_bits = 9;

    // ======================================================================
    // card byte stream
    // ======================================================================

    // one byte from the card controller
    // counted in every cycle that valid is high
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } sd_byte_t;

    // captured sector head
    // element 0 is the first byte off the card
    typedef logic [capture_bytes-1:0][7:0] capture_buf_t;

endpackage

`default_nettype wire

// File: design/sector_capture.sv
`timescale 1ns/100ps
`default_nettype none

module sector_capture (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic                 sd_ready,
    input  sd_pkg::sd_byte_t     sd_in,
    output logic                 sd_rd,
    output logic                 card_up,
    output sd_pkg::capture_buf_t buffer,
    output logic                 full
);

    // card seen ready once
    logic              greeted;
    // read request already sent
    logic              rd_issued;
    // bytes stored so far
    sd_pkg::byte_idx_t byte_cnt;
    logic              room_left;
    logic              take_byte;

    // ======================================================================
    // byte acceptance
    // ======================================================================

    // stop counting at the buffer size
    assign room_left = (byte_cnt < sd_pkg::byte_idx_t'(sd_pkg::capture_bytes));

    // only bytes after our own read request
    assign take_byte = sd_in.valid && rd_issued && room_left;

    // level once the last slot is filled
    assign full = (byte_cnt == sd_pkg::byte_idx_t'(sd_pkg::capture_bytes));

    // ======================================================================
    // card bring-up and read request
    // ======================================================================

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            greeted   <= 1'b0;
            card_up   <= 1'b0;
            rd_issued <= 1'b0;
            sd_rd     <= 1'b0;
            byte_cnt  <= '0;
        end else begin
            // both are single-cycle strobes
            card_up <= 1'b0;
            sd_rd   <= 1'b0;

            // first ready sample
            if (sd_ready && !greeted) begin
                greeted <= 1'b1;
                card_up <= 1'b1;
            end

            // read goes out right behind the greeting
            // skipped if the card dropped ready meanwhile
            if (card_up && sd_ready && !rd_issued) begin
                rd_issued <= 1'b1;
                sd_rd     <= 1'b1;
            end

            if (take_byte) begin
                byte_cnt <= byte_cnt + sd_pkg::byte_idx_t'(1);
            end
        end
    end

    // ======================================================================
    // capture buffer
    // ======================================================================

    // slot picked by the running count
    always_ff @(posedge CLOCK_50) begin
        if (take_byte) begin
            buffer[byte_cnt[3:0]] <= sd_in.data;
        end
    end

    // one read strobe per request
    sd_rd_single: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0) sd_rd |=> !sd_rd
    ) else $error("sd_rd high in two consecutive cycles");

    // count holds at the buffer size
    byte_cnt_bound: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        byte_cnt <= sd_pkg::byte_idx_t'(sd_pkg::capture_bytes)
    ) else $error("capture count past buffer size");

endmodule

`default_nettype wire

// File: design/tick_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tick_gen (
    input  logic CLOCK_50,
    input  logic KEY0,
    output logic ledr0,
    output logic sd_pulse
);

    // one free-running count for both the LED and the SD pacing
    logic [console_pkg::heartbeat_bits-1:0] tick_cnt;
    logic                                   div_wrap;

    // low divider field back at zero
    assign div_wrap = (tick_cnt[sd_pkg::pulse_div_bits-1:0] == '0);

    // ======================================================================
    // counter and strobe
    // ======================================================================

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            tick_cnt <= '0;
            sd_pulse <= 1'b0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            // strobe the cycle after each wrap
            sd_pulse <= div_wrap;
        end
    end

    // heartbeat from the msb
    // too slow to toggle within a short run
    assign ledr0 = tick_cnt[console_pkg::heartbeat_bits-1];

    // strobe is a single cycle wide
    sd_pulse_single: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0) sd_pulse |=> !sd_pulse
    ) else $error("sd_pulse high in two consecutive cycles");

endmodule

`default_nettype wire

// File: dv/sd_dump_tb.sv
`timescale 1ns/100ps
`default_nettype none

module sd_dump_tb;

    // ======================================================================
    // test table
    // ======================================================================

    localparam int n_rows      = 5;
    localparam int n_chars     = 1 + 2 * 16;
    localparam int tail_cycles = 40;
    // budget per row covers reset, bytes with gaps, dump and tail
    localparam int cycle_limit = n_rows * (30 + 16 * 3 + 16 * 4 + 60);

    // element 0 of each row is the first byte sent
    string            row_name  [n_rows] = '{"zeros", "ones", "boundary", "ramp", "mixed"};
    logic [0:15][7:0] row_data  [n_rows] = '{
        128'h0000_0000_0000_0000_0000_0000_0000_0000,
        128'hFFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF,
        128'h9AA9_090A_90A0_99AA_00FF_19F0_AF5C_3E7B,
        128'h0011_2233_4455_6677_8899_AABB_CCDD_EEFF,
        128'h0123_4567_89AB_CDEF_FEDC_BA98_7654_3210
    };
    // bytes sent past the 16th with lfsr values
    int               row_extra [n_rows] = '{0, 3, 2, 5, 8};

    // ======================================================================
    // DUT and clock
    // ======================================================================

    logic                       CLOCK_50 = 1'b0;
    logic                       KEY0;
    logic                       sd_ready;
    sd_pkg::sd_byte_t           sd_in;
    logic                       ledr0;
    logic                       sd_pulse;
    logic                       sd_rd;
    console_pkg::console_word_t console;

    sd_dump_top sd_dump_top_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .sd_ready (sd_ready),
        .sd_in    (sd_in),
        .ledr0    (ledr0),
        .sd_pulse (sd_pulse),
        .sd_rd    (sd_rd),
        .console  (console)
    );

    // 20 ns period
    always #10 CLOCK_50 = ~CLOCK_50;

    // scoreboard state
    console_pkg::console_word_t char_q [$];
    int          rd_count;
    int          run_cyc;
    logic        pulse_bad;
    logic        ledr_seen;
    int          error_cnt  = 0;
    int          check_cnt  = 0;
    int          cycle_cnt  = 0;
    logic [31:0] lfsr_state = 32'd89137;

    // ======================================================================
    // helpers
    // ======================================================================

    // galois step with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // upper-case hex digit by table lookup
    function automatic logic [7:0] ascii_hex(input logic [3:0] n);
        string digits;
        digits = "0123456789ABCDEF";
        return digits[int'(n)];
    endfunction

    function automatic console_pkg::console_word_t expected_word(input logic [7:0] c);
        console_pkg::console_word_t w;
        w.write = 1'b1;
        w.data  = {24'h0, c};
        return w;
    endfunction

    task automatic char_compare(input string name, input console_pkg::console_word_t exp,
                                input console_pkg::console_word_t act);
        check_cnt++;
        if (act !== exp) begin
            error_cnt++;
            $display("[ERROR] %s: expected write=%b data=%08h, got write=%b data=%08h",
                     name, exp.write, exp.data, act.write, act.data);
        end
    endtask

    task automatic flag_compare(input string name, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            error_cnt++;
            $display("[ERROR] %s: expected %b, got %b", name, exp, act);
        end
    endtask

    // ======================================================================
    // monitor sampled away from the driving edge
    // ======================================================================

    always @(negedge CLOCK_50) begin
        if (KEY0 === 1'b1) begin
            // strobe due in the cycle after each 512 wrap
            if (sd_pulse !== (run_cyc % 512 == 1)) begin
                pulse_bad = 1'b1;
            end
            if (ledr0 !== 1'b0) begin
                ledr_seen = 1'b1;
            end
            if (sd_rd === 1'b1) begin
                rd_count = rd_count + 1;
            end
            if (console.write === 1'b1) begin
                char_q.push_back(console);
            end
            run_cyc = run_cyc + 1;
        end
    end

    // run limit
    always @(posedge CLOCK_50) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run went past %0d cycles without finishing", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ======================================================================
    // stimulus
    // ======================================================================

    task automatic apply_reset();
        @(posedge CLOCK_50);
        KEY0     <= 1'b0;
        sd_ready <= 1'b0;
        sd_in    <= '0;
        repeat (3) @(posedge CLOCK_50);
        // monitor is idle while reset is low
        char_q.delete();
        rd_count  = 0;
        run_cyc   = 0;
        pulse_bad = 1'b0;
        ledr_seen = 1'b0;
        KEY0 <= 1'b1;
    endtask

    // random gap of 0 to 3 cycles then one valid byte
    task automatic send_byte(input logic [7:0] b);
        logic [7:0] gap;
        take_bits(2, gap);
        repeat (gap) begin
            @(posedge CLOCK_50);
            sd_in <= '0;
        end
        @(posedge CLOCK_50);
        sd_in <= '{valid: 1'b1, data: b};
    endtask

    task automatic run_row(input int r);
        string                      name;
        logic [7:0]                 extra_byte;
        logic [7:0]                 b;
        console_pkg::console_word_t exp_w;
        int                         err_before;
        name       = row_name[r];
        err_before = error_cnt;
        apply_reset();

        // quiet before the card is ready
        repeat (4) @(negedge CLOCK_50);
        flag_compare({name, " sd_rd idle"}, 1'b0, sd_rd);
        flag_compare({name, " console idle"}, 1'b0, console.write);
        flag_compare({name, " ledr0 idle"}, 1'b0, ledr0);

        @(posedge CLOCK_50);
        sd_ready <= 1'b1;
        while (sd_rd !== 1'b1) begin
            @(negedge CLOCK_50);
        end

        for (int i = 0; i < 16; i++) begin
            send_byte(row_data[r][i]);
        end
        for (int i = 0; i < row_extra[r]; i++) begin
            take_bits(8, extra_byte);
            send_byte(extra_byte);
        end
        @(posedge CLOCK_50);
        sd_in <= '0;

        // whole dump then a quiet tail for stray writes
        while (char_q.size() < n_chars) begin
            @(posedge CLOCK_50);
        end
        repeat (tail_cycles) @(posedge CLOCK_50);

        if (char_q.size() != n_chars) begin
            $display("%s: got %0d console writes instead of %0d", name, char_q.size(), n_chars);
        end
        flag_compare({name, " console write count"}, 1'b1, char_q.size() == n_chars);
        for (int i = 0; i < n_chars && i < char_q.size(); i++) begin
            b = row_data[r][(i - 1) / 2];
            if (i == 0) begin
                exp_w = expected_word(8'h4B);
            end else if ((i - 1) % 2 == 0) begin
                exp_w = expected_word(ascii_hex(b[7:4]));
            end else begin
                exp_w = expected_word(ascii_hex(b[3:0]));
            end
            char_compare($sformatf("%s char %0d", name, i), exp_w, char_q[i]);
        end
        flag_compare({name, " single sd_rd"}, 1'b1, rd_count == 1);
        flag_compare({name, " sd_pulse period"}, 1'b0, pulse_bad);
        flag_compare({name, " ledr0 low"}, 1'b0, ledr_seen);

        if (error_cnt == err_before) begin
            $display("test %s done, no errors", name);
        end else begin
            $display("test %s done, %0d errors", name, error_cnt - err_before);
        end
    endtask

    initial begin
        KEY0     <= 1'b0;
        sd_ready <= 1'b0;
        sd_in    <= '0;
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        $display("tests %0d, checks %0d, errors %0d", n_rows, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the sd_dump testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f sd_dump.f \
    --top-module sd_dump_tb -Mdir obj_dir \
    && ./obj_dir/Vsd_dump_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "no pass line in log"; exit 1; }
echo "simulation passed"

// File: sd_dump.f
design/sd_pkg.sv
design/console_pkg.sv
design/tick_gen.sv
design/sector_capture.sv
design/hex_console.sv
design/sd_dump_top.sv
dv/sd_dump_tb.sv
